/* Bender.yml */
package:
  name: cp0

export_include_dirs:
  - src

sources:
  - src/cp0_reg_pkg.sv
  - src/cp0_exc_pkg.sv
  - src/cp0_ctrl_if.sv
  - src/cp0_regfile.sv
  - src/cp0_timer.sv
  - src/cp0_exc_ctrl.sv
  - src/cp0_top.sv
  - target: test
    files:
      - dv/cp0_checker.sv
      - dv/cp0_tb.sv

/* compile.f */
+incdir+src
src/cp0_reg_pkg.sv
src/cp0_exc_pkg.sv
src/cp0_ctrl_if.sv
src/cp0_regfile.sv
src/cp0_timer.sv
src/cp0_exc_ctrl.sv
src/cp0_top.sv
dv/cp0_checker.sv
dv/cp0_tb.sv

/* dv/cp0_checker.sv */
/*
 * Scoreboard for the CP0 testbench.
 * Keeps a cycle model of the CP0 state built from the register map
 * and the exception rules, compares every DUT output on the falling
 * clock edge and counts checks and mismatches for the testbench.
 */

`include "cp0_settings.svh"

module cp0_checker import cp0_reg_pkg::*, cp0_exc_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [2:0]   phase,          // Current test step
    input  cp0_word_t    pc,
    input  cp0_reg_num_t reg_num,
    input  cp0_reg_sel_t reg_sel,
    input  cp0_word_t    reg_wd,
    input  logic         reg_we,
    input  cp0_word_t    reg_rd,
    input  cp0_word_t    epc,
    input  logic [5:0]   exc_ip,
    input  logic         exc_ri,
    input  logic         exc_ov,
    input  logic         exc_eret,
    input  logic         exc_async_req,
    input  logic         exc_async_ack,
    input  logic         exc_async,
    input  logic         exc_sync,
    input  logic         ti,
    output int           checks,
    output int           errors
);

    // Model state
    logic       m_ie;
    logic       m_exl;
    logic       m_dc;
    logic       m_ti;
    logic [7:0] m_im;
    logic [1:0] m_ip_sw;                 // Cause IP[1:0]
    logic [5:0] m_ip_hw;                 // Cause IP[7:2]
    logic [4:0] m_code;                  // ExcCode
    cp0_word_t  m_count;
    cp0_word_t  m_compare;
    cp0_word_t  m_epc;

    initial begin
        checks = 0;
        errors = 0;
    end

    function automatic string phase_name(input logic [2:0] p);
        case (p)
            3'd1:    return "register_readback";
            3'd2:    return "timer";
            3'd3:    return "sync_exception";
            3'd4:    return "interrupt";
            3'd5:    return "eret";
            3'd6:    return "random_traffic";
            default: return "reset";
        endcase
    endfunction

    task automatic check_val(input string what, input cp0_word_t exp, input cp0_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s %s: expected %h actual %h at %0t",
                     phase_name(phase), what, exp, act, $time);
        end
    endtask

    // ####################
    // Expected read data

    function automatic cp0_word_t exp_read();
        cp0_word_t v;
        v = '0;                          // Reserved and unknown read zero
        if (reg_sel == 3'd0) begin
            case (reg_num)
                CP0_NUM_COUNT:   v = m_count;
                CP0_NUM_COMPARE: v = m_compare;
                CP0_NUM_EPC:     v = m_epc;
                CP0_NUM_STATUS: begin
                    v[STATUS_IE_BIT]               = m_ie;
                    v[STATUS_EXL_BIT]              = m_exl;
                    v[STATUS_IM_MSB:STATUS_IM_LSB] = m_im;
                end
                CP0_NUM_CAUSE: begin
                    v[CAUSE_EXC_MSB:CAUSE_EXC_LSB] = m_code;
                    v[CAUSE_IP_MSB:CAUSE_IP_LSB]   = {m_ip_hw, m_ip_sw};
                    v[CAUSE_DC_BIT]                = m_dc;
                    v[CAUSE_TI_BIT]                = m_ti;
                end
                default: v = '0;
            endcase
        end
        return v;
    endfunction

    task automatic reset_model();
        m_ie      = 1'b0;
        m_exl     = 1'b0;
        m_dc      = 1'b0;
        m_ti      = 1'b0;
        m_im      = '0;
        m_ip_sw   = '0;
        m_ip_hw   = '0;
        m_code    = '0;
        m_count   = '0;
        m_compare = `CP0_COMPARE_RESET;  // Only non-zero reset
        m_epc     = '0;
    endtask

    task automatic compare_outputs();
        check_val("reg_rd", exp_read(), reg_rd);
        check_val("epc", m_epc, epc);
        check_val("exc_async_req", (|({m_ip_hw, m_ip_sw} & m_im)) & ~m_exl, exc_async_req);
        check_val("exc_async", exc_async_ack & ~m_exl, exc_async);
        check_val("exc_sync", (exc_ri | exc_ov) & ~m_exl, exc_sync);
        check_val("ti", m_ti, ti);
    endtask

    // ####################
    // Next state, old values read first

    task automatic advance_model();
        logic sync;
        logic take;
        logic wr_ok;
        sync  = (exc_ri | exc_ov) & ~m_exl;
        take  = sync | (exc_async_ack & ~m_exl);
        wr_ok = reg_we && (reg_sel == 3'd0);
        if (wr_ok && reg_num == CP0_NUM_COMPARE)
            m_ti = 1'b0;                 // Compare write acks TI
        else if (m_ie && !m_dc && m_count == m_compare)
            m_ti = 1'b1;
        if (wr_ok && reg_num == CP0_NUM_COUNT)
            m_count = reg_wd;
        else if (!m_dc)
            m_count = m_count + 1;
        if (exc_eret)
            m_ip_hw = '0;
        else if (m_ie && !m_exl)
            m_ip_hw = exc_ip;            // Lines seen one cycle late
        if (take)
            m_code = exc_ri ? CP0_EXC_RI : (exc_ov ? CP0_EXC_OV : CP0_EXC_INT);
        if (wr_ok && reg_num == CP0_NUM_EPC)
            m_epc = reg_wd;
        else if (take)
            m_epc = pc;
        if (wr_ok && reg_num == CP0_NUM_STATUS) begin
            m_exl = reg_wd[STATUS_EXL_BIT];  // SW write beats eret
            m_ie  = reg_wd[STATUS_IE_BIT];
            m_im  = reg_wd[STATUS_IM_MSB:STATUS_IM_LSB];
        end else if (exc_eret) begin
            m_exl = 1'b0;
        end else if (take) begin
            m_exl = 1'b1;
        end
        if (wr_ok && reg_num == CP0_NUM_CAUSE) begin
            m_dc    = reg_wd[CAUSE_DC_BIT];
            m_ip_sw = reg_wd[CAUSE_IP_LSB+1:CAUSE_IP_LSB];
        end
        if (wr_ok && reg_num == CP0_NUM_COMPARE)
            m_compare = reg_wd;
    endtask

    // Inputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            compare_outputs();
            advance_model();
        end
    end

endmodule

/* dv/cp0_tb.sv */
/*
 * Testbench for the CP0 coprocessor.
 * Plays the CPU: register traffic, exception inputs and acks, first
 * in directed steps and then from an LCG. The checker next to the
 * DUT compares every output against its own model.
 */

module cp0_tb import cp0_reg_pkg::*; ();

    localparam int CLK_HALF  = 20;       // 40 unit period
    localparam int DRIVE_DLY = 2;        // Inputs change after the edge

    logic         clk;
    logic         rst_n;
    cp0_word_t    pc;
    cp0_reg_num_t reg_num;
    cp0_reg_sel_t reg_sel;
    cp0_word_t    reg_wd;
    logic         reg_we;
    cp0_word_t    reg_rd;
    cp0_word_t    epc;
    logic [5:0]   exc_ip;
    logic         exc_ri;
    logic         exc_ov;
    logic         exc_eret;
    logic         exc_async_req;
    logic         exc_async_ack;
    logic         exc_async;
    logic         exc_sync;
    logic         ti;
    logic [2:0]   phase;
    logic [31:0]  lcg_state;
    int           checks;
    int           errors;
    int           timeouts;

    cp0_top dut_i (.*);

    cp0_checker checker_i (.*);

    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ####################
    // CPU side actions

    task automatic tick();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic reg_write(input cp0_reg_num_t num, input cp0_word_t wd);
        reg_num = num;
        reg_sel = '0;
        reg_wd  = wd;
        reg_we  = 1'b1;
        tick();
        reg_we  = 1'b0;
    endtask

    task automatic reg_read(input cp0_reg_num_t num, input cp0_reg_sel_t sel);
        reg_num = num;                   // Checker compares reg_rd
        reg_sel = sel;
        tick();
    endtask

    task automatic pulse_exc(input logic ri, input logic ov, input logic eret, input logic ack);
        pc            = rand_word() & 32'hffff_fffc;
        exc_ri        = ri;
        exc_ov        = ov;
        exc_eret      = eret;
        exc_async_ack = ack;
        tick();
        exc_ri        = 1'b0;
        exc_ov        = 1'b0;
        exc_eret      = 1'b0;
        exc_async_ack = 1'b0;
    endtask

    // Polls on the falling edge and then realigns to the drive slot
    task automatic wait_high(input bit use_ti, input int limit, input string what);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = use_ti ? ti : exc_async_req;
            n++;
        end
        tick();
        if (!seen) begin
            timeouts++;
            $display("Timeout: no %s within %0d cycles", what, limit);
        end
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        logic [31:0] s;
        r = rand_word();
        s = rand_word();
        case (r[31:29])                  // Mostly real registers
            3'd0:    reg_num = CP0_NUM_COUNT;
            3'd1:    reg_num = CP0_NUM_COMPARE;
            3'd2:    reg_num = CP0_NUM_STATUS;
            3'd3:    reg_num = CP0_NUM_CAUSE;
            3'd4:    reg_num = CP0_NUM_EPC;
            default: reg_num = r[24:20];
        endcase
        reg_sel       = (r[19:17] == 3'd0) ? r[16:14] : 3'd0;   // Rare bad select
        reg_we        = (r[28:26] == 3'd0);
        reg_wd        = rand_word();
        pc            = rand_word() & 32'hffff_fffc;
        exc_ip        = s[31:26];
        exc_ri        = (s[25:23] == 3'd0);
        exc_ov        = (s[22:20] == 3'd0);
        exc_eret      = (s[19:16] == 4'd0);
        exc_async_ack = (s[15:14] == 2'd0);
        tick();
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        pc            = '0;
        reg_num       = '0;
        reg_sel       = '0;
        reg_wd        = '0;
        reg_we        = 1'b0;
        exc_ip        = '0;
        exc_ri        = 1'b0;
        exc_ov        = 1'b0;
        exc_eret      = 1'b0;
        exc_async_ack = 1'b0;
        phase         = 3'd0;
        timeouts      = 0;
        lcg_state     = 32'hc640;
        repeat (2) @(posedge clk);
        #DRIVE_DLY rst_n = 1'b1;

        // ####################
        // Register readback
        phase = 3'd1;
        repeat (4) begin
            reg_write(CP0_NUM_STATUS, rand_word());
            reg_read(CP0_NUM_STATUS, 3'd0);
            reg_write(CP0_NUM_CAUSE, rand_word());
            reg_read(CP0_NUM_CAUSE, 3'd0);
            reg_write(CP0_NUM_COMPARE, rand_word());
            reg_read(CP0_NUM_COMPARE, 3'd0);
            reg_write(CP0_NUM_EPC, rand_word());
            reg_read(CP0_NUM_EPC, 3'd0);
            reg_write(CP0_NUM_COUNT, rand_word());
            reg_read(CP0_NUM_COUNT, 3'd0);
            reg_read(CP0_NUM_STATUS, 3'd1);      // Wrong select
            reg_read(5'd31, 3'd0);               // Unmapped
        end

        // ####################
        // Timer match and freeze
        phase = 3'd2;
        reg_write(CP0_NUM_STATUS, 32'h0000_0001);   // IE set and no mask bits
        reg_write(CP0_NUM_CAUSE, 32'h0);
        reg_write(CP0_NUM_COMPARE, 32'd40);
        reg_write(CP0_NUM_COUNT, 32'd0);
        reg_num = CP0_NUM_COUNT;                    // Watch Count run
        wait_high(1'b1, 100, "timer interrupt");
        reg_write(CP0_NUM_COMPARE, 32'hffff_ffff);  // Acks TI
        reg_write(CP0_NUM_CAUSE, 32'h0800_0000);    // DC set
        reg_write(CP0_NUM_COUNT, 32'd500);
        reg_write(CP0_NUM_COMPARE, 32'd500);
        repeat (8) reg_read(CP0_NUM_COUNT, 3'd0);   // Frozen Count and no TI
        reg_write(CP0_NUM_CAUSE, 32'h0);
        wait_high(1'b1, 20, "timer interrupt after unfreeze");
        reg_write(CP0_NUM_COMPARE, 32'hffff_ffff);

        // ####################
        // Synchronous exceptions
        phase = 3'd3;
        reg_write(CP0_NUM_STATUS, 32'h0);
        pulse_exc(1'b1, 1'b1, 1'b0, 1'b0);          // RI beats OV
        reg_read(CP0_NUM_CAUSE, 3'd0);
        pulse_exc(1'b0, 1'b1, 1'b0, 1'b0);          // Ignored under EXL
        reg_read(CP0_NUM_EPC, 3'd0);
        pulse_exc(1'b0, 1'b0, 1'b1, 1'b0);
        pulse_exc(1'b0, 1'b1, 1'b0, 1'b0);
        reg_read(CP0_NUM_CAUSE, 3'd0);
        pulse_exc(1'b0, 1'b0, 1'b1, 1'b0);

        // ####################
        // Interrupts
        phase = 3'd4;
        reg_write(CP0_NUM_STATUS, 32'h0000_0401);   // IE and IM[2] only
        exc_ip = 6'b000010;                          // Masked line
        repeat (6) reg_read(CP0_NUM_CAUSE, 3'd0);
        exc_ip = 6'b000011;
        wait_high(1'b0, 20, "interrupt request");
        repeat (3) tick();                           // Held until ack
        pulse_exc(1'b0, 1'b0, 1'b0, 1'b1);
        reg_read(CP0_NUM_CAUSE, 3'd0);
        reg_read(CP0_NUM_EPC, 3'd0);

        // ####################
        // Return with the line still high
        phase = 3'd5;
        pulse_exc(1'b0, 1'b0, 1'b1, 1'b0);
        wait_high(1'b0, 20, "interrupt request after eret");
        pulse_exc(1'b0, 1'b0, 1'b0, 1'b1);
        exc_ip = '0;
        pulse_exc(1'b0, 1'b0, 1'b1, 1'b0);
        reg_write(CP0_NUM_STATUS, 32'h0000_0101);   // IM[0] for the software bit
        reg_write(CP0_NUM_CAUSE, 32'h0000_0100);
        wait_high(1'b0, 20, "software interrupt request");
        pulse_exc(1'b0, 1'b0, 1'b0, 1'b1);
        reg_write(CP0_NUM_CAUSE, 32'h0);
        pulse_exc(1'b0, 1'b0, 1'b1, 1'b0);

        // ####################
        // Random traffic
        phase = 3'd6;
        repeat (400) random_cycle();
        reg_we        = 1'b0;            // Back to idle
        exc_ri        = 1'b0;
        exc_ov        = 1'b0;
        exc_eret      = 1'b0;
        exc_async_ack = 1'b0;
        tick();
        @(posedge clk);                  // Last falling edge compare is done

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* src/cp0_ctrl_if.sv */
/*
 * Internal control bundle of the CP0 coprocessor.
 * Connects the register block, the Count timer and the exception
 * controller. Each modport owns the signals its block drives.
 */

interface cp0_ctrl_if import cp0_reg_pkg::*, cp0_exc_pkg::*; ();

    // Register block side
    logic [7:0]    im;                   // Status IM
    logic          ie;                   // Status IE
    logic          dc;                   // Cause DC
    logic [1:0]    ip_sw;                // Cause IP[1:0]
    cp0_word_t     compare;
    logic          compare_wr;           // SW write strobes
    logic          count_wr;
    cp0_word_t     wd;                   // Write data for count load
    logic          status_wr;
    logic          exl_wd;               // EXL bit of the write data

    // Timer side
    cp0_word_t     count;
    logic          ti;                   // Sticky timer flag

    // Exception controller side
    logic          exl;
    logic [5:0]    ip_hw;                // Cause IP[7:2]
    cp0_exc_code_t exc_code;
    logic          exc_take;             // One cycle, EPC capture

    modport regs (
        output im, ie, dc, ip_sw, compare, compare_wr, count_wr, wd, status_wr, exl_wd,
        input  count, ti, exl, ip_hw, exc_code, exc_take
    );
    modport timer (input dc, ie, compare, compare_wr, count_wr, wd, output count, ti);
    modport exc (input im, ie, ip_sw, status_wr, exl_wd, output exl, ip_hw, exc_code, exc_take);

endinterface

/* src/cp0_exc_ctrl.sv */
/*
 * Exception control of CP0.
 * Owns Status EXL, the sampled hardware pending bits and ExcCode.
 * Raises the interrupt request, passes the CPU ack through as
 * exc_async, flags RI/OV as exc_sync and pulses exc_take so the
 * register block saves the PC.
 */

module cp0_exc_ctrl import cp0_exc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  logic [5:0] exc_ip,           // HW interrupt lines
    input  logic       exc_ri,           // Reserved instruction
    input  logic       exc_ov,           // Overflow
    input  logic       exc_eret,         // Return from handler
    input  logic       exc_async_ack,    // CPU takes the interrupt

    output logic       exc_async_req,
    output logic       exc_async,
    output logic       exc_sync,

    cp0_ctrl_if.exc    ctrl
);

    logic [7:0]    ip_all;
    logic          sync_req;
    logic          exl_next;
    logic [5:0]    ip_hw_next;
    cp0_exc_code_t code_next;

    // ####################
    // Requests

    assign ip_all   = {ctrl.ip_hw, ctrl.ip_sw};  // Full Cause IP
    assign sync_req = exc_ri | exc_ov;

    // Held high until ack, blocked while in a handler
    assign exc_async_req = (|(ip_all & ctrl.im)) & ~ctrl.exl;
    assign exc_async     = exc_async_ack & ~ctrl.exl;
    assign exc_sync      = sync_req & ~ctrl.exl;

    assign ctrl.exc_take = exc_async | exc_sync; // EPC capture

    // ####################
    // Exception level

    // SW write > eret > set by a taken exception
    always_comb begin
        if (ctrl.status_wr)
            exl_next = ctrl.exl_wd;
        else if (exc_eret)
            exl_next = 1'b0;
        else
            exl_next = ctrl.exl | ctrl.exc_take;
    end

    // ####################
    // HW pending bits

    always_comb begin
        ip_hw_next = ctrl.ip_hw;
        if (exc_eret)
            ip_hw_next = '0;                     // Clean slate on return
        else if (!ctrl.exl && ctrl.ie)
            ip_hw_next = exc_ip;                 // Sample the lines
    end

    assign code_next = cp0_exc_pick(exc_ri, exc_ov);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl.exl      <= 1'b0;
            ctrl.ip_hw    <= '0;
            ctrl.exc_code <= CP0_EXC_INT;
        end else begin
            ctrl.exl   <= exl_next;
            ctrl.ip_hw <= ip_hw_next;
            if (ctrl.exc_take)
                ctrl.exc_code <= code_next;      // Only on a taken exception
        end
    end

endmodule

/* src/cp0_exc_pkg.sv */
/*
 * Exception codes of the CP0 coprocessor.
 * The enum values are the ExcCode encodings of the architecture.
 * The helper picks the code for a taken exception.
 */

package cp0_exc_pkg;

    typedef enum logic [4:0] {
        CP0_EXC_INT = 5'd0,              // Interrupt
        CP0_EXC_RI  = 5'd10,             // Reserved instruction
        CP0_EXC_OV  = 5'd12              // Arithmetic overflow
    } cp0_exc_code_t;

    // RI beats OV, anything else is an interrupt
    function automatic cp0_exc_code_t cp0_exc_pick(input logic ri, input logic ov);
        if (ri)
            return CP0_EXC_RI;
        if (ov)
            return CP0_EXC_OV;
        return CP0_EXC_INT;
    endfunction

endpackage

/* src/cp0_reg_pkg.sv */
/*
 * Register map of the CP0 coprocessor.
 * Holds the word types, the register number and select values and
 * the bit positions of the Status and Cause fields. Used by every
 * block that decodes or assembles a CP0 register.
 */

`include "cp0_settings.svh"

package cp0_reg_pkg;

    typedef logic [`CP0_DATA_W-1:0] cp0_word_t;    // Data word
    typedef logic [4:0]             cp0_reg_num_t; // Register number
    typedef logic [2:0]             cp0_reg_sel_t; // Register select

    // Register numbers, select 0 for all
    localparam cp0_reg_num_t CP0_NUM_COUNT   = 5'd9;
    localparam cp0_reg_num_t CP0_NUM_COMPARE = 5'd11;
    localparam cp0_reg_num_t CP0_NUM_STATUS  = 5'd12;
    localparam cp0_reg_num_t CP0_NUM_CAUSE   = 5'd13;
    localparam cp0_reg_num_t CP0_NUM_EPC     = 5'd14;
    localparam cp0_reg_sel_t CP0_SEL_0       = 3'd0;

    // Status fields
    localparam int STATUS_IE_BIT  = 0;   // Interrupt enable
    localparam int STATUS_EXL_BIT = 1;   // Exception level
    localparam int STATUS_IM_LSB  = 8;   // Interrupt mask
    localparam int STATUS_IM_MSB  = 15;

    // Cause fields
    localparam int CAUSE_EXC_LSB  = 2;   // Exception code
    localparam int CAUSE_EXC_MSB  = 6;
    localparam int CAUSE_IP_LSB   = 8;   // Pending bits
    localparam int CAUSE_IP_MSB   = 15;
    localparam int CAUSE_DC_BIT   = 27;  // Count disable
    localparam int CAUSE_TI_BIT   = 30;  // Timer interrupt

endpackage

/* src/cp0_regfile.sv */
/*
 * Software view of CP0.
 * Decodes register number and select, returns read data in the
 * same cycle and stores Status IE/IM, Cause DC/IP[1:0], Compare
 * and EPC. Writes owned by other blocks leave as strobes.
 */

`include "cp0_settings.svh"

module cp0_regfile import cp0_reg_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,

    input  cp0_reg_num_t reg_num,        // Access address
    input  cp0_reg_sel_t reg_sel,
    input  cp0_word_t    reg_wd,         // Write data
    input  logic         reg_we,         // Write on next edge
    output cp0_word_t    reg_rd,         // Combinational read

    input  cp0_word_t    pc,             // Resume address
    output cp0_word_t    epc,

    cp0_ctrl_if.regs     ctrl
);

    logic      sel_count;
    logic      sel_compare;
    logic      sel_status;
    logic      sel_cause;
    logic      sel_epc;
    logic      status_ld;
    logic      cause_ld;
    logic      epc_ld;
    cp0_word_t status_rd;
    cp0_word_t cause_rd;

    // ####################
    // Address decode

    assign sel_count   = (reg_num == CP0_NUM_COUNT)   && (reg_sel == CP0_SEL_0);
    assign sel_compare = (reg_num == CP0_NUM_COMPARE) && (reg_sel == CP0_SEL_0);
    assign sel_status  = (reg_num == CP0_NUM_STATUS)  && (reg_sel == CP0_SEL_0);
    assign sel_cause   = (reg_num == CP0_NUM_CAUSE)   && (reg_sel == CP0_SEL_0);
    assign sel_epc     = (reg_num == CP0_NUM_EPC)     && (reg_sel == CP0_SEL_0);

    assign status_ld = reg_we & sel_status;
    assign cause_ld  = reg_we & sel_cause;
    assign epc_ld    = reg_we & sel_epc;

    // Strobes to the timer and the exception controller
    assign ctrl.compare_wr = reg_we & sel_compare;   // Also clears TI
    assign ctrl.count_wr   = reg_we & sel_count;
    assign ctrl.status_wr  = status_ld;
    assign ctrl.exl_wd     = reg_wd[STATUS_EXL_BIT];
    assign ctrl.wd         = reg_wd;

    // ####################
    // Storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl.ie      <= 1'b0;
            ctrl.im      <= '0;
            ctrl.dc      <= 1'b0;
            ctrl.ip_sw   <= '0;
            ctrl.compare <= `CP0_COMPARE_RESET;
            epc          <= '0;
        end else begin
            if (status_ld) begin
                ctrl.ie <= reg_wd[STATUS_IE_BIT];
                ctrl.im <= reg_wd[STATUS_IM_MSB:STATUS_IM_LSB];
            end
            if (cause_ld) begin
                ctrl.dc    <= reg_wd[CAUSE_DC_BIT];
                ctrl.ip_sw <= reg_wd[CAUSE_IP_LSB+1:CAUSE_IP_LSB]; // SW bits only
            end
            if (ctrl.compare_wr)
                ctrl.compare <= reg_wd;
            // SW write first, then exception capture
            if (epc_ld)
                epc <= reg_wd;
            else if (ctrl.exc_take)
                epc <= pc;
        end
    end

    // ####################
    // Read side

    always_comb begin
        status_rd                              = '0;     // Reserved bits read zero
        status_rd[STATUS_IE_BIT]               = ctrl.ie;
        status_rd[STATUS_EXL_BIT]              = ctrl.exl;
        status_rd[STATUS_IM_MSB:STATUS_IM_LSB] = ctrl.im;
    end

    always_comb begin
        cause_rd                             = '0;
        cause_rd[CAUSE_EXC_MSB:CAUSE_EXC_LSB] = ctrl.exc_code;
        cause_rd[CAUSE_IP_MSB:CAUSE_IP_LSB]   = {ctrl.ip_hw, ctrl.ip_sw};
        cause_rd[CAUSE_DC_BIT]                = ctrl.dc;
        cause_rd[CAUSE_TI_BIT]                = ctrl.ti;
    end

    always_comb begin
        if (sel_compare)
            reg_rd = ctrl.compare;
        else if (sel_count)
            reg_rd = ctrl.count;
        else if (sel_status)
            reg_rd = status_rd;
        else if (sel_cause)
            reg_rd = cause_rd;
        else if (sel_epc)
            reg_rd = epc;
        else
            reg_rd = '0;                         // Unknown address
    end

endmodule

/* src/cp0_settings.svh */
/*
 * Build-time constants for the CP0 coprocessor.
 * Include this header wherever the data width, the reset values
 * or the exception handler address are needed. The CPU model takes
 * the handler address from here because CP0 has no output for it.
 */

`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

// ####################
// Datapath

`define CP0_DATA_W 32                      // Register and bus width

// ####################
// Fixed addresses and reset values

// Jump target on any exception, general vector
`define CP0_EXC_HANDLER_ADDR 32'h0000_0100

// All ones, so no early timer hit after reset
`define CP0_COMPARE_RESET 32'hffff_ffff

`endif

/* src/cp0_timer.sv */
/*
 * Count register and timer interrupt flag.
 * Count runs every cycle unless Cause DC is set, a SW write loads
 * it. TI sets one edge after a Count/Compare match and holds until
 * Compare is written.
 */

module cp0_timer import cp0_reg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    cp0_ctrl_if.timer ctrl
);

    cp0_word_t count_next;
    logic      hit;

    // ####################
    // Count

    always_comb begin
        count_next = ctrl.count;
        if (ctrl.count_wr)
            count_next = ctrl.wd;                // Load wins over freeze
        else if (!ctrl.dc)
            count_next = ctrl.count + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ctrl.count <= '0;
        else
            ctrl.count <= count_next;
    end

    // ####################
    // Timer flag

    // Match only counts while enabled and running
    assign hit = ctrl.ie & ~ctrl.dc & (ctrl.count == ctrl.compare);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ctrl.ti <= 1'b0;
        else if (ctrl.compare_wr)
            ctrl.ti <= 1'b0;                     // Acknowledge by Compare write
        else if (hit)
            ctrl.ti <= 1'b1;                     // Sticky
    end

endmodule

/* src/cp0_top.sv */
/*
 * CP0 coprocessor top level.
 * Plain ports toward the CPU, the internal blocks share one control
 * interface. Register port reads combinationally and writes on the
 * clock edge, exceptions follow the req/ack handshake.
 */

module cp0_top import cp0_reg_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,

    input  cp0_word_t    pc,             // Resume PC from the CPU
    input  cp0_reg_num_t reg_num,
    input  cp0_reg_sel_t reg_sel,
    input  cp0_word_t    reg_wd,
    input  logic         reg_we,
    output cp0_word_t    reg_rd,
    output cp0_word_t    epc,

    input  logic [5:0]   exc_ip,         // HW interrupts
    input  logic         exc_ri,
    input  logic         exc_ov,
    input  logic         exc_eret,
    output logic         exc_async_req,
    input  logic         exc_async_ack,
    output logic         exc_async,
    output logic         exc_sync,
    output logic         ti              // Timer interrupt
);

    cp0_ctrl_if ctrl ();

    cp0_regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .reg_num (reg_num),
        .reg_sel (reg_sel),
        .reg_wd  (reg_wd),
        .reg_we  (reg_we),
        .reg_rd  (reg_rd),
        .pc      (pc),
        .epc     (epc),
        .ctrl    (ctrl.regs)
    );

    cp0_timer timer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl.timer)
    );

    cp0_exc_ctrl exc_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .exc_ip        (exc_ip),
        .exc_ri        (exc_ri),
        .exc_ov        (exc_ov),
        .exc_eret      (exc_eret),
        .exc_async_ack (exc_async_ack),
        .exc_async_req (exc_async_req),
        .exc_async     (exc_async),
        .exc_sync      (exc_sync),
        .ctrl          (ctrl.exc)
    );

    assign ti = ctrl.ti;                     // Straight from the sticky flag

endmodule
